// File: ldiCore.f
hdl/ldiPkg.sv
hdl/waitTimer.sv
hdl/registerFile.sv
hdl/busDatapath.sv
hdl/programMemory.sv
hdl/controlSequencer.sv
hdl/ldiCore.sv
verification/clockGen.sv
verification/ldiCoreTb.sv

// File: Bender.yml
package:
  name: ldiCore

sources:
  - hdl/ldiPkg.sv
  - hdl/waitTimer.sv
  - hdl/registerFile.sv
  - hdl/busDatapath.sv
  - hdl/programMemory.sv
  - hdl/controlSequencer.sv
  - hdl/ldiCore.sv
  - target: simulation
    files:
      - verification/clockGen.sv
      - verification/ldiCoreTb.sv

// File: verification/ldiCoreTb.sv
// Directed ldiCore testbench that loads programs, runs them and checks registers by peek
`timescale 1ns/100ps
module ldiCoreTb;

   localparam int Timeout = 2000;

   logic             Clock;
   logic             rstN;
   logic             runReq;
   logic             runAck;
   logic             progWe;
   ldiPkg::memAddr_t progAddr;
   ldiPkg::word_t    progData;
   ldiPkg::regIdx_t  peekSel;
   ldiPkg::word_t    peekData;

   // Reference register contents and the program under construction
   ldiPkg::word_t model [16];
   ldiPkg::word_t prog [$];

   clockGen clkSource (.Clock (Clock));

   ldiCore UUT (
      .Clock (Clock), .rstN (rstN),
      .runReq (runReq), .runAck (runAck),
      .progWe (progWe), .progAddr (progAddr), .progData (progData),
      .peekSel (peekSel), .peekData (peekData)
   );

   task automatic reportFailure(input string msg);
      $display("%s", msg);
      $display("Checks failed");
      $fatal(1);
   endtask

   // Inputs change and outputs are sampled 2 ns after the rising edge
   task automatic waitCycle();
      @(posedge Clock);
      #2;
   endtask

   task automatic resetDut();
      rstN   = 1'b0;
      runReq = 1'b0;
      progWe = 1'b0;
      repeat (10) waitCycle();
      rstN = 1'b1;
      foreach (model[i]) model[i] = '0;
      prog.delete();
   endtask

   task automatic loadWord(input int addr, input ldiPkg::word_t data);
      progWe   = 1'b1;
      progAddr = ldiPkg::memAddr_t'(addr);
      progData = data;
      waitCycle();
      progWe = 1'b0;
   endtask

   // Queue an ldi and apply it to the model with R0 as a zero base
   task automatic addLdi(input int ra, input int rb, input int c);
      logic [18:0]   cField;
      ldiPkg::word_t base;
      cField = c[18:0];
      base   = (rb == 0) ? '0 : model[rb];
      prog.push_back({5'd0, 4'(ra), 4'(rb), cField});
      model[ra] = base + {{13{cField[18]}}, cField};
   endtask

   // Any opcode other than ldi and halt leaves the registers alone
   task automatic addOther(input int op);
      prog.push_back({5'(op), 27'($urandom)});
   endtask

   task automatic addHalt();
      prog.push_back({5'd31, 27'd0});
   endtask

   task automatic waitRunAck(input logic level, output int cycles);
      cycles = 0;
      while (runAck !== level && cycles < Timeout) begin
         waitCycle();
         cycles++;
      end
      assert (runAck === level) else
         reportFailure(level ? "runAck never rose within the timeout"
                             : "runAck never fell within the timeout");
   endtask

   task automatic peekCheck(input int idx);
      peekSel = ldiPkg::regIdx_t'(idx);
      waitCycle();
      assert (peekData === model[idx]) else
         reportFailure($sformatf("[FAIL] time=%0t signal=peekData(R%0d) expected=%h actual=%h",
                                 $time, idx, model[idx], peekData));
   endtask

   task automatic compareAllRegs();
      for (int i = 0; i < 16; i++) begin
         peekCheck(i);
      end
   endtask

   // Load the queued program, run it and hold runReq for a while after runAck
   task automatic runProgram(input int hold);
      int cycles;
      foreach (prog[i]) loadWord(i, prog[i]);
      prog.delete();
      runReq = 1'b1;
      waitRunAck(1'b1, cycles);
      repeat (hold) begin
         waitCycle();
         assert (runAck === 1'b1) else
            reportFailure($sformatf("[FAIL] time=%0t signal=runAck expected=1 actual=%b",
                                    $time, runAck));
      end
      runReq = 1'b0;
      waitRunAck(1'b0, cycles);
      assert (cycles == 1) else
         reportFailure($sformatf("[FAIL] time=%0t signal=runAck fall delay expected=1 actual=%0d",
                                 $time, cycles));
      compareAllRegs();
   endtask

   task automatic checkResetState();
      resetDut();
      assert (runAck === 1'b0) else
         reportFailure($sformatf("[FAIL] time=%0t signal=runAck expected=0 actual=%b",
                                 $time, runAck));
      compareAllRegs();
   endtask

   task automatic loadConstants();
      addLdi(1, 0, 5);
      addLdi(2, 0, -7);
      addLdi(15, 0, 'h3FFFF);
      addLdi(7, 0, -'h40000);
      addLdi(1, 0, -1);
      addHalt();
      runProgram(0);
   endtask

   task automatic offsetChains();
      addLdi(3, 0, 100);
      addLdi(4, 3, -30);
      addLdi(4, 4, 12);
      addLdi(4, 4, -1);
      addLdi(5, 15, 'h1000);
      // R0 holds a value yet still reads zero as a base
      addLdi(0, 0, 9);
      addLdi(6, 0, 1);
      addLdi(6, 6, -2);
      addHalt();
      runProgram(1);
   endtask

   task automatic skipOtherOpcodes();
      addLdi(8, 0, 3);
      addOther(1);
      addOther(5);
      addLdi(9, 8, 4);
      addOther(30);
      addOther(16);
      addHalt();
      runProgram(2);
   endtask

   task automatic randomPrograms();
      int count;
      repeat (3) begin
         count = 4 + $urandom % 9;
         repeat (count) addLdi($urandom % 16, $urandom % 16, $urandom);
         addHalt();
         runProgram($urandom % 6);
      end
   endtask

   initial begin
      void'($urandom(49533));
      rstN     = 1'b0;
      runReq   = 1'b0;
      progWe   = 1'b0;
      progAddr = '0;
      progData = '0;
      peekSel  = '0;
      checkResetState();
      loadConstants();
      offsetChains();
      skipOtherOpcodes();
      randomPrograms();
      $display("All checks passed");
      $finish;
   end

endmodule

// File: verification/clockGen.sv
// Free-running testbench clock with a 20 ns period, instantiated by the ldiCore testbench
`timescale 1ns/100ps
module clockGen (
   output logic Clock
);

   initial begin
      Clock = 1'b0;
   end

   // Half period of 10 ns
   always #10 Clock = ~Clock;

endmodule

// File: hdl/ldiCore.sv
// Top level of the ldi core connecting sequencer, datapath, register file and program memory
`timescale 1ns/100ps
module ldiCore (
   input  logic             Clock,
   input  logic             rstN,
   input  logic             runReq,
   output logic             runAck,
   input  logic             progWe,
   input  ldiPkg::memAddr_t progAddr,
   input  ldiPkg::word_t    progData,
   input  ldiPkg::regIdx_t  peekSel,
   output ldiPkg::word_t    peekData
);

   logic pcOut, mdrOut, rOut, rzOut, immOut;
   logic pcIn, marIn, mdrIn, irIn, ryIn, rzIn, regIn;
   logic incPc, pcClear;
   logic memReq, memAck;

   ldiPkg::word_t    bus;
   ldiPkg::word_t    regData;
   ldiPkg::word_t    memData;
   ldiPkg::memAddr_t marAddr;
   ldiPkg::opcode_t  opcode;
   ldiPkg::regIdx_t  raSel;
   ldiPkg::regIdx_t  rbSel;

   controlSequencer sequencer (
      .Clock (Clock), .rstN (rstN),
      .runReq (runReq), .runAck (runAck),
      .memReq (memReq), .memAck (memAck), .opcode (opcode),
      .pcOut (pcOut), .mdrOut (mdrOut), .rOut (rOut), .rzOut (rzOut), .immOut (immOut),
      .pcIn (pcIn), .marIn (marIn), .mdrIn (mdrIn), .irIn (irIn),
      .ryIn (ryIn), .rzIn (rzIn), .regIn (regIn),
      .incPc (incPc), .pcClear (pcClear)
   );

   busDatapath datapath (
      .Clock (Clock), .rstN (rstN),
      .pcOut (pcOut), .mdrOut (mdrOut), .rOut (rOut), .rzOut (rzOut), .immOut (immOut),
      .pcIn (pcIn), .marIn (marIn), .mdrIn (mdrIn), .irIn (irIn),
      .ryIn (ryIn), .rzIn (rzIn), .regIn (regIn),
      .incPc (incPc), .pcClear (pcClear),
      .regData (regData), .memData (memData), .bus (bus), .marAddr (marAddr),
      .opcode (opcode), .raSel (raSel), .rbSel (rbSel)
   );

   registerFile regFile (
      .Clock (Clock), .rstN (rstN),
      .regIn (regIn), .raSel (raSel), .rbSel (rbSel), .bus (bus),
      .regData (regData), .peekSel (peekSel), .peekData (peekData)
   );

   programMemory progMem (
      .Clock (Clock), .rstN (rstN),
      .progWe (progWe), .progAddr (progAddr), .progData (progData),
      .marAddr (marAddr), .memReq (memReq), .memAck (memAck), .memData (memData)
   );

endmodule

// File: hdl/controlSequencer.sv
// Control FSM of the ldi core that owns both handshakes and drives the datapath strobes
`timescale 1ns/100ps
module controlSequencer (
   input  logic            Clock,
   input  logic            rstN,
   input  logic            runReq,
   output logic            runAck,
   output logic            memReq,
   input  logic            memAck,
   input  ldiPkg::opcode_t opcode,
   output logic            pcOut,
   output logic            mdrOut,
   output logic            rOut,
   output logic            rzOut,
   output logic            immOut,
   output logic            pcIn,
   output logic            marIn,
   output logic            mdrIn,
   output logic            irIn,
   output logic            ryIn,
   output logic            rzIn,
   output logic            regIn,
   output logic            incPc,
   output logic            pcClear
);

   ldiPkg::seqState_t state;
   ldiPkg::seqState_t nextState;

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         state <= ldiPkg::Idle;
      end else begin
         state <= nextState;
      end
   end

   always_comb begin
      nextState = state;
      runAck    = 1'b0;
      memReq    = 1'b0;
      pcOut     = 1'b0;
      mdrOut    = 1'b0;
      rOut      = 1'b0;
      rzOut     = 1'b0;
      immOut    = 1'b0;
      pcIn      = 1'b0;
      marIn     = 1'b0;
      mdrIn     = 1'b0;
      irIn      = 1'b0;
      ryIn      = 1'b0;
      rzIn      = 1'b0;
      regIn     = 1'b0;
      incPc     = 1'b0;
      pcClear   = 1'b0;
      case (state)
         ldiPkg::Idle: begin
            // New run zeroes the bus and loads it into PC
            if (runReq) begin
               pcClear   = 1'b1;
               pcIn      = 1'b1;
               nextState = ldiPkg::Fetch;
            end
         end
         ldiPkg::Fetch: begin
            pcOut     = 1'b1;
            marIn     = 1'b1;
            incPc     = 1'b1;
            nextState = ldiPkg::ReadReq;
         end
         ldiPkg::ReadReq: begin
            memReq = 1'b1;
            // MDR captures memData on the acknowledging edge
            if (memAck) begin
               mdrIn     = 1'b1;
               nextState = ldiPkg::ReadRelease;
            end
         end
         ldiPkg::ReadRelease: begin
            if (!memAck) begin
               nextState = ldiPkg::Decode;
            end
         end
         ldiPkg::Decode: begin
            mdrOut = 1'b1;
            irIn   = 1'b1;
            if (opcode == ldiPkg::OpLdi) begin
               nextState = ldiPkg::LoadBase;
            end else if (opcode == ldiPkg::OpHalt) begin
               nextState = ldiPkg::Done;
            end else begin
               nextState = ldiPkg::Fetch;
            end
         end
         ldiPkg::LoadBase: begin
            rOut      = 1'b1;
            ryIn      = 1'b1;
            nextState = ldiPkg::AddOffset;
         end
         ldiPkg::AddOffset: begin
            immOut    = 1'b1;
            rzIn      = 1'b1;
            nextState = ldiPkg::WriteBack;
         end
         ldiPkg::WriteBack: begin
            rzOut     = 1'b1;
            regIn     = 1'b1;
            nextState = ldiPkg::Fetch;
         end
         ldiPkg::Done: begin
            runAck = 1'b1;
            if (!runReq) begin
               nextState = ldiPkg::Idle;
            end
         end
         default: begin
            nextState = ldiPkg::Idle;
         end
      endcase
   end

endmodule

// File: hdl/programMemory.sv
// Program memory with a synchronous load port and a four-phase read port timed by waitTimer
`timescale 1ns/100ps
module programMemory (
   input  logic             Clock,
   input  logic             rstN,
   input  logic             progWe,
   input  ldiPkg::memAddr_t progAddr,
   input  ldiPkg::word_t    progData,
   input  ldiPkg::memAddr_t marAddr,
   input  logic             memReq,
   output logic             memAck,
   output ldiPkg::word_t    memData
);

   ldiPkg::word_t mem [ldiPkg::MemDepth];
   logic          reqSeen;
   logic          ackHold;
   logic          timerLoad;
   logic          timerDone;

   always_ff @(posedge Clock) begin
      if (progWe) begin
         mem[progAddr] <= progData;
      end
   end

   assign memData = mem[marAddr];

   // Start the latency count only on the first edge of a request
   assign timerLoad = memReq & ~reqSeen;

   waitTimer latencyTimer (
      .Clock (Clock),
      .rstN  (rstN),
      .load  (timerLoad),
      .done  (timerDone)
   );

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         reqSeen <= 1'b0;
         ackHold <= 1'b0;
      end else begin
         reqSeen <= memReq;
         ackHold <= memReq & (timerDone | ackHold);
      end
   end

   // Ack stays up while the request is held and drops with it
   assign memAck = memReq & (timerDone | ackHold);

endmodule

// File: hdl/busDatapath.sv
// Datapath of the ldi core with PC, MAR, MDR, IR, RY and RZ around one bus and an offset adder
`timescale 1ns/100ps
module busDatapath (
   input  logic             Clock,
   input  logic             rstN,
   input  logic             pcOut,
   input  logic             mdrOut,
   input  logic             rOut,
   input  logic             rzOut,
   input  logic             immOut,
   input  logic             pcIn,
   input  logic             marIn,
   input  logic             mdrIn,
   input  logic             irIn,
   input  logic             ryIn,
   input  logic             rzIn,
   input  logic             regIn,
   input  logic             incPc,
   input  logic             pcClear,
   input  ldiPkg::word_t    regData,
   input  ldiPkg::word_t    memData,
   output ldiPkg::word_t    bus,
   output ldiPkg::memAddr_t marAddr,
   output ldiPkg::opcode_t  opcode,
   output ldiPkg::regIdx_t  raSel,
   output ldiPkg::regIdx_t  rbSel
);

   ldiPkg::memAddr_t pc;
   ldiPkg::memAddr_t mar;
   ldiPkg::word_t    mdr;
   ldiPkg::word_t    ir;
   ldiPkg::word_t    ry;
   ldiPkg::word_t    rz;
   ldiPkg::word_t    baseVal;
   ldiPkg::word_t    constExt;

   // Instruction fields
   assign raSel = ir[ldiPkg::RaHi:ldiPkg::RaLo];
   assign rbSel = ir[ldiPkg::RbHi:ldiPkg::RbLo];
   assign constExt = {{(32 - ldiPkg::ConstWidth){ir[ldiPkg::ConstHi]}}, ir[ldiPkg::ConstHi:0]};

   // R0 as a base reads as zero
   assign baseVal = (rbSel == '0) ? '0 : regData;

   // While IR loads, show the incoming opcode so the FSM decodes in the same step
   assign opcode = irIn ? bus[ldiPkg::OpcodeHi:ldiPkg::OpcodeLo]
                        : ir[ldiPkg::OpcodeHi:ldiPkg::OpcodeLo];

   assign marAddr = mar;

   // One-hot sources; pcClear forces zero onto the bus
   always_comb begin
      bus = ({32{pcOut}}  & ldiPkg::word_t'(pc))
          | ({32{mdrOut}} & mdr)
          | ({32{rOut}}   & baseVal)
          | ({32{rzOut}}  & rz)
          | ({32{immOut}} & constExt);
      if (pcClear) begin
         bus = '0;
      end
   end

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         pc  <= '0;
         mar <= '0;
         mdr <= '0;
         ir  <= '0;
         ry  <= '0;
         rz  <= '0;
      end else begin
         if (pcIn) begin
            pc <= ldiPkg::memAddr_t'(bus);
         end else if (incPc) begin
            pc <= pc + 1'b1;
         end
         if (marIn) begin
            mar <= ldiPkg::memAddr_t'(bus);
         end
         if (mdrIn) begin
            mdr <= memData;
         end
         if (irIn) begin
            ir <= bus;
         end
         if (ryIn) begin
            ry <= bus;
         end
         // Offset adder feeds RZ
         if (rzIn) begin
            rz <= ry + bus;
         end
      end
   end

endmodule

// File: hdl/registerFile.sv
// General register file with one bus write port, a base read port and a separate peek port
`timescale 1ns/100ps
module registerFile (
   input  logic            Clock,
   input  logic            rstN,
   input  logic            regIn,
   input  ldiPkg::regIdx_t raSel,
   input  ldiPkg::regIdx_t rbSel,
   input  ldiPkg::word_t   bus,
   output ldiPkg::word_t   regData,
   input  ldiPkg::regIdx_t peekSel,
   output ldiPkg::word_t   peekData
);

   ldiPkg::word_t regs [ldiPkg::RegCount];

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < ldiPkg::RegCount; i++) begin
            regs[i] <= '0;
         end
      end else if (regIn) begin
         regs[raSel] <= bus;
      end
   end

   // Base operand for the datapath
   assign regData = regs[rbSel];

   // Observation port independent of the core
   assign peekData = regs[peekSel];

endmodule

// File: hdl/waitTimer.sv
// Latency counter for the program memory that pulses done when a loaded count reaches zero
`timescale 1ns/100ps
module waitTimer (
   input  logic Clock,
   input  logic rstN,
   input  logic load,
   output logic done
);

   logic [ldiPkg::TimerWidth-1:0] count;

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         count <= '0;
         done  <= 1'b0;
      end else begin
         done <= 1'b0;
         if (load) begin
            count <= ldiPkg::TimerWidth'(ldiPkg::MemLatency);
         end else if (count != '0) begin
            count <= count - 1'b1;
            // Flag the cycle in which the count becomes zero
            if (count == ldiPkg::TimerWidth'(1)) begin
               done <= 1'b1;
            end
         end
      end
   end

endmodule

// File: hdl/ldiPkg.sv
// Shared types, opcodes, instruction field positions and sizing constants for the ldi core
package ldiPkg;

   // Sizing
   localparam int MemDepth   = 64;
   localparam int MemLatency = 3;
   localparam int TimerWidth = $clog2(MemLatency + 1);
   localparam int RegCount   = 16;

   // Instruction field positions
   localparam int OpcodeHi   = 31;
   localparam int OpcodeLo   = 27;
   localparam int RaHi       = 26;
   localparam int RaLo       = 23;
   localparam int RbHi       = 22;
   localparam int RbLo       = 19;
   localparam int ConstWidth = 19;
   localparam int ConstHi    = ConstWidth - 1;

   typedef logic [31:0]                   word_t;
   typedef logic [3:0]                    regIdx_t;
   typedef logic [$clog2(MemDepth)-1:0]   memAddr_t;
   typedef logic [OpcodeHi-OpcodeLo:0]    opcode_t;

   localparam opcode_t OpLdi  = 5'd0;
   localparam opcode_t OpHalt = 5'd31;

   // Sequencer steps, one instruction at a time
   typedef enum logic [3:0] {
      Idle,
      Fetch,
      ReadReq,
      ReadRelease,
      Decode,
      LoadBase,
      AddOffset,
      WriteBack,
      Done
   } seqState_t;

endpackage
